//--- decodeCases.txt
// insn illegalPC mopType aluCode condCode accessMode mulDivCode srcRegA srcRegB dstReg
// typeA typeB imm writeReg writePC isRelBranch isCall isReturn illegalCause, all hex
002081B3 0 0 0 6 2 0 01 02 03 0 0 00000000 1 0 0 0 0 0
40628033 0 0 1 6 2 0 05 06 00 0 0 00000000 0 0 0 0 0 0
FFB58513 0 0 0 6 2 0 0B 00 0A 0 1 FFFFFFFB 1 0 0 0 0 0
40345393 0 1 9 6 2 0 08 00 07 0 1 00000003 1 0 0 0 0 0
00921233 0 1 7 6 2 0 04 09 04 0 0 00000000 1 0 0 0 0 0
7FF6B613 0 0 3 6 2 0 0D 00 0C 0 1 000007FF 1 0 0 0 0 0
ABCDE2B7 0 0 0 6 2 0 00 00 05 0 1 ABCDE000 1 0 0 0 0 0
00001317 0 0 0 6 2 0 00 00 06 2 1 00001000 1 0 0 0 0 0
FF9FF0EF 0 3 0 6 2 0 00 00 01 2 1 FFFFFFF8 1 1 1 1 0 0
00008067 0 4 0 6 2 0 01 00 00 0 1 00000000 0 1 0 0 1 0
010280E7 0 4 0 6 2 0 05 00 01 0 1 00000010 1 1 0 1 0 0
FE208EE3 0 2 0 0 2 0 01 02 00 0 0 FFFFFFFC 0 1 1 0 0 0
0041F0E3 0 2 0 5 2 0 03 04 00 0 0 00000800 0 1 1 0 0 0
FFF4D403 0 5 0 6 5 0 09 00 08 0 1 FFFFFFFF 1 0 0 0 0 0
FEA12023 0 6 0 6 2 0 02 0A 00 0 0 FFFFFFE0 0 0 0 0 0 0
00408783 0 5 0 6 0 0 01 00 0F 0 1 00000004 1 0 0 0 0 0
027322B3 0 7 0 6 2 2 06 07 05 0 0 00000000 1 0 0 0 0 0
036AFA33 0 8 0 6 2 7 15 16 14 0 0 00000000 1 0 0 0 0 0
0FF0000F 0 9 0 0 0 0 00 00 00 0 0 00000000 0 0 0 0 0 1
00000073 0 9 0 0 0 0 00 00 00 0 0 00000000 0 0 0 0 0 1
FFFFFFFF 0 9 0 0 0 0 00 00 00 0 0 00000000 0 0 0 0 0 1
002081B3 1 9 0 0 0 0 00 00 00 0 0 00000000 0 0 0 0 0 2
FF9FF0EF 1 9 0 0 0 0 00 00 00 0 0 00000000 0 0 0 0 0 2

//--- decodePkg.sv
// --------------------------------------------------
// Enumerated types of the RV32IM decode stage
// Opcodes, op classes, unit codes, operand sources,
// immediate formats and illegal causes
// --------------------------------------------------
package decodePkg;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        RISCV_LD     = 7'b0000011,
        RISCV_OP_IMM = 7'b0010011,
        RISCV_AUIPC  = 7'b0010111,
        RISCV_ST     = 7'b0100011,
        RISCV_OP     = 7'b0110011,
        RISCV_LUI    = 7'b0110111,
        RISCV_BR     = 7'b1100011,
        RISCV_JALR   = 7'b1100111,
        RISCV_JAL    = 7'b1101111
    } OpCode;

    // Op class of the micro-op
    typedef enum logic [3:0] {
        MOP_ALU,
        MOP_SHIFT,
        MOP_BR,
        MOP_JAL,
        MOP_RIJ,
        MOP_LOAD,
        MOP_STORE,
        MOP_MUL,
        MOP_DIV,
        MOP_ILLEGAL
    } MopType;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, XOR, OR, AND, SLL, SRL, SRA
    } AluCode;

    // AL is the always-taken code for non-branch ops
    typedef enum logic [2:0] {
        EQ, NE, LT, GE, LTU, GEU, AL
    } CondCode;

    // Values follow the load funct3 encoding
    typedef enum logic [2:0] {
        BYTE   = 3'b000,
        HALF   = 3'b001,
        WORD   = 3'b010,
        BYTE_U = 3'b100,
        HALF_U = 3'b101
    } AccessMode;

    // Values follow the M extension funct3 encoding
    typedef enum logic [2:0] {
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
    } MulDivCode;

    typedef enum logic [1:0] {
        OOT_REG, OOT_IMM, OOT_PC
    } OperandType;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } ImmType;

    typedef enum logic [1:0] {
        CAUSE_NONE, CAUSE_INSN, CAUSE_PC_VIOLATION
    } IllegalCause;

endpackage

//--- decodeStageReg.sv
// --------------------------------------------------
// Decode pipeline register with valid and stall
// --------------------------------------------------
`timescale 1ns/10ps
`include "decode_macros.svh"

module decodeStageReg (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      stall,
    input  logic                      insnValid,
    input  decodePkg::MopType         mopType,
    input  decodePkg::AluCode         aluCode,
    input  decodePkg::CondCode        condCode,
    input  decodePkg::AccessMode      accessMode,
    input  decodePkg::MulDivCode      mulDivCode,
    input  logic [`REG_NUM_WIDTH-1:0] srcRegA,
    input  logic [`REG_NUM_WIDTH-1:0] srcRegB,
    input  logic [`REG_NUM_WIDTH-1:0] dstReg,
    input  decodePkg::OperandType     opTypeA,
    input  decodePkg::OperandType     opTypeB,
    input  logic [`DATA_WIDTH-1:0]    imm,
    input  logic                      writeReg,
    input  logic                      writePC,
    input  logic                      isRelBranch,
    input  logic                      isCall,
    input  logic                      isReturn,
    input  decodePkg::IllegalCause    illegalCause,
    output logic                      opValid,
    output decodePkg::MopType         opMopType,
    output decodePkg::AluCode         opAluCode,
    output decodePkg::CondCode        opCondCode,
    output decodePkg::AccessMode      opAccessMode,
    output decodePkg::MulDivCode      opMulDivCode,
    output logic [`REG_NUM_WIDTH-1:0] opSrcRegA,
    output logic [`REG_NUM_WIDTH-1:0] opSrcRegB,
    output logic [`REG_NUM_WIDTH-1:0] opDstReg,
    output decodePkg::OperandType     opTypeAOut,
    output decodePkg::OperandType     opTypeBOut,
    output logic [`DATA_WIDTH-1:0]    opImm,
    output logic                      opWriteReg,
    output logic                      opWritePC,
    output logic                      opIsRelBranch,
    output logic                      opIsCall,
    output logic                      opIsReturn,
    output decodePkg::IllegalCause    opIllegalCause
);
    import decodePkg::*;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            // Every enum below encodes to zero
            opValid        <= 1'b0;
            opMopType      <= MOP_ALU;
            opAluCode      <= ADD;
            opCondCode     <= EQ;
            opAccessMode   <= BYTE;
            opMulDivCode   <= MUL;
            opSrcRegA      <= '0;
            opSrcRegB      <= '0;
            opDstReg       <= '0;
            opTypeAOut     <= OOT_REG;
            opTypeBOut     <= OOT_REG;
            opImm          <= '0;
            opWriteReg     <= 1'b0;
            opWritePC      <= 1'b0;
            opIsRelBranch  <= 1'b0;
            opIsCall       <= 1'b0;
            opIsReturn     <= 1'b0;
            opIllegalCause <= CAUSE_NONE;
        end else if (!stall) begin
            opValid        <= insnValid;
            opMopType      <= mopType;
            opAluCode      <= aluCode;
            opCondCode     <= condCode;
            opAccessMode   <= accessMode;
            opMulDivCode   <= mulDivCode;
            opSrcRegA      <= srcRegA;
            opSrcRegB      <= srcRegB;
            opDstReg       <= dstReg;
            opTypeAOut     <= opTypeA;
            opTypeBOut     <= opTypeB;
            opImm          <= imm;
            opWriteReg     <= writeReg;
            opWritePC      <= writePC;
            opIsRelBranch  <= isRelBranch;
            opIsCall       <= isCall;
            opIsReturn     <= isReturn;
            opIllegalCause <= illegalCause;
        end
    end

endmodule

//--- decodeTb.sv
// --------------------------------------------------
// Testbench of the RV32IM decode stage
// Case file reader, stimulus with random stalls,
// output checks and watchdog
// --------------------------------------------------
`timescale 1ns/10ps
`include "decode_macros.svh"

module decodeTb;
    import decodePkg::*;

    localparam int maxCases = 64;
    localparam int numCols  = 19;

    // Column positions in decodeCases.txt
    localparam int colInsn  = 0;
    localparam int colIpc   = 1;
    localparam int colMop   = 2;
    localparam int colAlu   = 3;
    localparam int colCond  = 4;
    localparam int colAcc   = 5;
    localparam int colMd    = 6;
    localparam int colSrcA  = 7;
    localparam int colSrcB  = 8;
    localparam int colDst   = 9;
    localparam int colTypeA = 10;
    localparam int colTypeB = 11;
    localparam int colImm   = 12;
    localparam int colWr    = 13;
    localparam int colWpc   = 14;
    localparam int colRel   = 15;
    localparam int colCall  = 16;
    localparam int colRet   = 17;
    localparam int colCause = 18;

    logic                      clk;
    logic                      rstN;
    logic                      insnValid;
    logic [`INSN_WIDTH-1:0]    insn;
    logic                      illegalPC;
    logic                      stall;
    logic                      opValid;
    MopType                    opMopType;
    AluCode                    opAluCode;
    CondCode                   opCondCode;
    AccessMode                 opAccessMode;
    MulDivCode                 opMulDivCode;
    logic [`REG_NUM_WIDTH-1:0] opSrcRegA;
    logic [`REG_NUM_WIDTH-1:0] opSrcRegB;
    logic [`REG_NUM_WIDTH-1:0] opDstReg;
    OperandType                opTypeA;
    OperandType                opTypeB;
    logic [`DATA_WIDTH-1:0]    opImm;
    logic                      opWriteReg;
    logic                      opWritePC;
    logic                      opIsRelBranch;
    logic                      opIsCall;
    logic                      opIsReturn;
    IllegalCause               opIllegalCause;

    logic [31:0] caseData [0:maxCases-1][0:numCols-1];
    int          caseCount = 0;
    logic        loadDone  = 1'b0;

    decodeTop u_decodeTop (
        .clk            (clk),
        .rstN           (rstN),
        .insnValid      (insnValid),
        .insn           (insn),
        .illegalPC      (illegalPC),
        .stall          (stall),
        .opValid        (opValid),
        .opMopType      (opMopType),
        .opAluCode      (opAluCode),
        .opCondCode     (opCondCode),
        .opAccessMode   (opAccessMode),
        .opMulDivCode   (opMulDivCode),
        .opSrcRegA      (opSrcRegA),
        .opSrcRegB      (opSrcRegB),
        .opDstReg       (opDstReg),
        .opTypeA        (opTypeA),
        .opTypeB        (opTypeB),
        .opImm          (opImm),
        .opWriteReg     (opWriteReg),
        .opWritePC      (opWritePC),
        .opIsRelBranch  (opIsRelBranch),
        .opIsCall       (opIsCall),
        .opIsReturn     (opIsReturn),
        .opIllegalCause (opIllegalCause)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic compareField(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected)
        else abortRun($sformatf("ERR %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    task automatic loadCases();
        int          fd;
        int          count;
        string       lineText;
        logic [31:0] col [numCols];
        fd = $fopen("decodeCases.txt", "r");
        if (fd == 0) begin
            abortRun("Cannot open decodeCases.txt");
        end
        while (!$feof(fd)) begin
            lineText = "";
            void'($fgets(lineText, fd));
            // Lines starting with a slash are comments
            if (lineText.len() > 0 && lineText.getc(0) != 8'h2f) begin
                count = $sscanf(lineText,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                    col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                    col[14], col[15], col[16], col[17], col[18]);
                if (count == numCols) begin
                    if (caseCount == maxCases) begin
                        abortRun("Too many cases in decodeCases.txt");
                    end
                    for (int j = 0; j < numCols; j++) begin
                        caseData[caseCount][j] = col[j];
                    end
                    caseCount++;
                end
            end
        end
        $fclose(fd);
        if (caseCount == 0) begin
            abortRun("No cases found in decodeCases.txt");
        end
        loadDone = 1'b1;
    endtask

    // Register contents right after reset
    task automatic checkIdle();
        compareField("opValid", 32'h0, 32'(opValid));
        compareField("opMopType", 32'h0, 32'(opMopType));
        compareField("opAluCode", 32'h0, 32'(opAluCode));
        compareField("opCondCode", 32'h0, 32'(opCondCode));
        compareField("opAccessMode", 32'h0, 32'(opAccessMode));
        compareField("opMulDivCode", 32'h0, 32'(opMulDivCode));
        compareField("opSrcRegA", 32'h0, 32'(opSrcRegA));
        compareField("opSrcRegB", 32'h0, 32'(opSrcRegB));
        compareField("opDstReg", 32'h0, 32'(opDstReg));
        compareField("opTypeA", 32'h0, 32'(opTypeA));
        compareField("opTypeB", 32'h0, 32'(opTypeB));
        compareField("opImm", 32'h0, opImm);
        compareField("opWriteReg", 32'h0, 32'(opWriteReg));
        compareField("opWritePC", 32'h0, 32'(opWritePC));
        compareField("opIsRelBranch", 32'h0, 32'(opIsRelBranch));
        compareField("opIsCall", 32'h0, 32'(opIsCall));
        compareField("opIsReturn", 32'h0, 32'(opIsReturn));
        compareField("opIllegalCause", 32'h0, 32'(opIllegalCause));
    endtask

    task automatic checkCase(input int idx);
        MopType mop;
        mop = MopType'(caseData[idx][colMop][3:0]);
        compareField("opValid", 32'h1, 32'(opValid));
        compareField("opMopType", caseData[idx][colMop], 32'(opMopType));
        compareField("opWriteReg", caseData[idx][colWr], 32'(opWriteReg));
        compareField("opWritePC", caseData[idx][colWpc], 32'(opWritePC));
        compareField("opIsRelBranch", caseData[idx][colRel], 32'(opIsRelBranch));
        compareField("opIsCall", caseData[idx][colCall], 32'(opIsCall));
        compareField("opIsReturn", caseData[idx][colRet], 32'(opIsReturn));
        compareField("opIllegalCause", caseData[idx][colCause], 32'(opIllegalCause));
        // Other fields of an illegal op carry no meaning
        if (mop != MOP_ILLEGAL) begin
            compareField("opCondCode", caseData[idx][colCond], 32'(opCondCode));
            compareField("opSrcRegA", caseData[idx][colSrcA], 32'(opSrcRegA));
            compareField("opSrcRegB", caseData[idx][colSrcB], 32'(opSrcRegB));
            compareField("opDstReg", caseData[idx][colDst], 32'(opDstReg));
            compareField("opTypeA", caseData[idx][colTypeA], 32'(opTypeA));
            compareField("opTypeB", caseData[idx][colTypeB], 32'(opTypeB));
            compareField("opImm", caseData[idx][colImm], opImm);
            if (mop inside {MOP_ALU, MOP_SHIFT, MOP_JAL, MOP_RIJ}) begin
                compareField("opAluCode", caseData[idx][colAlu], 32'(opAluCode));
            end
            if (mop inside {MOP_LOAD, MOP_STORE}) begin
                compareField("opAccessMode", caseData[idx][colAcc], 32'(opAccessMode));
            end
            if (mop inside {MOP_MUL, MOP_DIV}) begin
                compareField("opMulDivCode", caseData[idx][colMd], 32'(opMulDivCode));
            end
        end
    endtask

    initial begin : watchdog
        wait (loadDone);
        repeat (caseCount * 4 + 40) @(posedge clk);
        abortRun($sformatf("Watchdog timeout after %0d clock periods", caseCount * 4 + 40));
    end

    initial begin : stimulus
        int stallCycles;
        int prevIdx;
        rstN      = 1'b0;
        insnValid = 1'b0;
        insn      = '0;
        illegalPC = 1'b0;
        stall     = 1'b0;
        prevIdx   = -1;
        void'($urandom(91272));
        loadCases();

        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b1;
        checkIdle();

        for (int idx = 0; idx < caseCount; idx++) begin
            stallCycles = int'($urandom % 3);
            insn        = caseData[idx][colInsn];
            illegalPC   = caseData[idx][colIpc][0];
            insnValid   = 1'b1;
            stall       = (stallCycles != 0);
            // New case waits at the input while the register holds the old one
            for (int s = 0; s < stallCycles; s++) begin
                @(posedge clk);
                #2;
                if (prevIdx < 0) begin
                    checkIdle();
                end else begin
                    checkCase(prevIdx);
                end
            end
            stall = 1'b0;
            @(posedge clk);
            #2;
            checkCase(idx);
            prevIdx = idx;
        end

        // Bubble after the last case
        insnValid = 1'b0;
        @(posedge clk);
        #2;
        compareField("opValid", 32'h0, 32'(opValid));
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- decodeTop.sv
// --------------------------------------------------
// RV32IM decode stage top level
// Classifier, immediate generator and field decoder
// feeding the output register
// --------------------------------------------------
`timescale 1ns/10ps
`include "decode_macros.svh"

module decodeTop (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      insnValid,
    input  logic [`INSN_WIDTH-1:0]    insn,
    input  logic                      illegalPC,
    input  logic                      stall,
    output logic                      opValid,
    output decodePkg::MopType         opMopType,
    output decodePkg::AluCode         opAluCode,
    output decodePkg::CondCode        opCondCode,
    output decodePkg::AccessMode      opAccessMode,
    output decodePkg::MulDivCode      opMulDivCode,
    output logic [`REG_NUM_WIDTH-1:0] opSrcRegA,
    output logic [`REG_NUM_WIDTH-1:0] opSrcRegB,
    output logic [`REG_NUM_WIDTH-1:0] opDstReg,
    output decodePkg::OperandType     opTypeA,
    output decodePkg::OperandType     opTypeB,
    output logic [`DATA_WIDTH-1:0]    opImm,
    output logic                      opWriteReg,
    output logic                      opWritePC,
    output logic                      opIsRelBranch,
    output logic                      opIsCall,
    output logic                      opIsReturn,
    output decodePkg::IllegalCause    opIllegalCause
);
    import decodePkg::*;

    MopType                    mopType;
    AluCode                    aluCode;
    CondCode                   condCode;
    AccessMode                 accessMode;
    MulDivCode                 mulDivCode;
    logic [`REG_NUM_WIDTH-1:0] srcRegA;
    logic [`REG_NUM_WIDTH-1:0] srcRegB;
    logic [`REG_NUM_WIDTH-1:0] dstReg;
    OperandType                typeA;
    OperandType                typeB;
    ImmType                    immType;
    logic [`DATA_WIDTH-1:0]    imm;
    logic                      writeReg;
    logic                      writePC;
    logic                      isRelBranch;
    logic                      isCall;
    logic                      isReturn;
    IllegalCause               illegalCause;

    opClassifier u_opClassifier (
        .insn         (insn),
        .illegalPC    (illegalPC),
        .mopType      (mopType),
        .srcRegA      (srcRegA),
        .srcRegB      (srcRegB),
        .dstReg       (dstReg),
        .opTypeA      (typeA),
        .opTypeB      (typeB),
        .immType      (immType),
        .writeReg     (writeReg),
        .writePC      (writePC),
        .isRelBranch  (isRelBranch),
        .isCall       (isCall),
        .isReturn     (isReturn),
        .illegalCause (illegalCause)
    );

    immGenerator u_immGenerator (
        .insn    (insn),
        .immType (immType),
        .imm     (imm)
    );

    opFieldDecoder u_opFieldDecoder (
        .insn       (insn),
        .mopType    (mopType),
        .aluCode    (aluCode),
        .condCode   (condCode),
        .accessMode (accessMode),
        .mulDivCode (mulDivCode)
    );

    decodeStageReg u_decodeStageReg (
        .clk            (clk),
        .rstN           (rstN),
        .stall          (stall),
        .insnValid      (insnValid),
        .mopType        (mopType),
        .aluCode        (aluCode),
        .condCode       (condCode),
        .accessMode     (accessMode),
        .mulDivCode     (mulDivCode),
        .srcRegA        (srcRegA),
        .srcRegB        (srcRegB),
        .dstReg         (dstReg),
        .opTypeA        (typeA),
        .opTypeB        (typeB),
        .imm            (imm),
        .writeReg       (writeReg),
        .writePC        (writePC),
        .isRelBranch    (isRelBranch),
        .isCall         (isCall),
        .isReturn       (isReturn),
        .illegalCause   (illegalCause),
        .opValid        (opValid),
        .opMopType      (opMopType),
        .opAluCode      (opAluCode),
        .opCondCode     (opCondCode),
        .opAccessMode   (opAccessMode),
        .opMulDivCode   (opMulDivCode),
        .opSrcRegA      (opSrcRegA),
        .opSrcRegB      (opSrcRegB),
        .opDstReg       (opDstReg),
        .opTypeAOut     (opTypeA),
        .opTypeBOut     (opTypeB),
        .opImm          (opImm),
        .opWriteReg     (opWriteReg),
        .opWritePC      (opWritePC),
        .opIsRelBranch  (opIsRelBranch),
        .opIsCall       (opIsCall),
        .opIsReturn     (opIsReturn),
        .opIllegalCause (opIllegalCause)
    );

endmodule

//--- decode_macros.svh
// --------------------------------------------------
// Widths and special register numbers
// --------------------------------------------------
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

`define INSN_WIDTH    32
`define DATA_WIDTH    32
`define REG_NUM_WIDTH 5

// x0 is hardwired zero, x1 is the return address
`define ZERO_REGISTER 5'd0
`define LINK_REGISTER 5'd1

`endif

//--- decode_properties.sv
// --------------------------------------------------
// Concurrent assertions on the decode stage outputs
// Bound into decodeTop
// --------------------------------------------------
`timescale 1ns/10ps
`include "decode_macros.svh"

module decodeProperties (
    input logic                      clk,
    input logic                      rstN,
    input logic                      stall,
    input logic                      opValid,
    input decodePkg::MopType         opMopType,
    input decodePkg::AluCode         opAluCode,
    input decodePkg::CondCode        opCondCode,
    input decodePkg::AccessMode      opAccessMode,
    input decodePkg::MulDivCode      opMulDivCode,
    input logic [`REG_NUM_WIDTH-1:0] opSrcRegA,
    input logic [`REG_NUM_WIDTH-1:0] opSrcRegB,
    input logic [`REG_NUM_WIDTH-1:0] opDstReg,
    input decodePkg::OperandType     opTypeA,
    input decodePkg::OperandType     opTypeB,
    input logic [`DATA_WIDTH-1:0]    opImm,
    input logic                      opWriteReg,
    input logic                      opWritePC,
    input logic                      opIsRelBranch,
    input logic                      opIsCall,
    input logic                      opIsReturn,
    input decodePkg::IllegalCause    opIllegalCause
);
    import decodePkg::*;

    validLowInReset: assert property (@(posedge clk) !rstN |-> !opValid)
        else $error("opValid high while rstN is low");

    // Illegal ops must not update any architectural state
    illegalNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        (opMopType == MOP_ILLEGAL) |-> !(opWriteReg || opWritePC))
        else $error("Illegal op with opWriteReg or opWritePC high");

    stallHolds: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> $stable({opValid, opMopType, opAluCode, opCondCode, opAccessMode,
                           opMulDivCode, opSrcRegA, opSrcRegB, opDstReg, opTypeA,
                           opTypeB, opImm, opWriteReg, opWritePC, opIsRelBranch,
                           opIsCall, opIsReturn, opIllegalCause}))
        else $error("Outputs changed while stall was high");

endmodule

bind decodeTop decodeProperties u_decodeProperties (.*);

//--- immGenerator.sv
// --------------------------------------------------
// Immediate generator for the I, S, B, U and J formats
// --------------------------------------------------
`timescale 1ns/10ps
`include "decode_macros.svh"

module immGenerator (
    input  logic [`INSN_WIDTH-1:0] insn,
    input  decodePkg::ImmType      immType,
    output logic [`DATA_WIDTH-1:0] imm
);
    import decodePkg::*;

    logic sign;
    logic isShiftImm;

    assign sign       = insn[31];
    // SLLI, SRLI and SRAI carry funct7 in the upper I bits
    assign isShiftImm = (insn[6:0] == RISCV_OP_IMM) && (insn[13:12] == 2'b01);

    always_comb begin
        case (immType)
            IMM_I: begin
                if (isShiftImm) begin
                    imm = {{(`DATA_WIDTH-5){1'b0}}, insn[24:20]};
                end else begin
                    imm = {{(`DATA_WIDTH-12){sign}}, insn[31:20]};
                end
            end
            IMM_S: imm = {{(`DATA_WIDTH-12){sign}}, insn[31:25], insn[11:7]};
            IMM_B: imm = {{(`DATA_WIDTH-13){sign}}, sign, insn[7], insn[30:25],
                          insn[11:8], 1'b0};
            IMM_U: imm = {insn[31:12], {(`DATA_WIDTH-20){1'b0}}};
            IMM_J: imm = {{(`DATA_WIDTH-21){sign}}, sign, insn[19:12], insn[20],
                          insn[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- opClassifier.sv
// --------------------------------------------------
// Op classifier of the decode stage
// Op class, registers, operand sources, immediate
// format, control-flow hints and illegal detection
// --------------------------------------------------
`timescale 1ns/10ps
`include "decode_macros.svh"

module opClassifier (
    input  logic [`INSN_WIDTH-1:0]    insn,
    input  logic                      illegalPC,
    output decodePkg::MopType         mopType,
    output logic [`REG_NUM_WIDTH-1:0] srcRegA,
    output logic [`REG_NUM_WIDTH-1:0] srcRegB,
    output logic [`REG_NUM_WIDTH-1:0] dstReg,
    output decodePkg::OperandType     opTypeA,
    output decodePkg::OperandType     opTypeB,
    output decodePkg::ImmType         immType,
    output logic                      writeReg,
    output logic                      writePC,
    output logic                      isRelBranch,
    output logic                      isCall,
    output logic                      isReturn,
    output decodePkg::IllegalCause    illegalCause
);
    import decodePkg::*;

    OpCode                     opCode;
    logic [2:0]                funct3;
    logic [6:0]                funct7;
    logic [`REG_NUM_WIDTH-1:0] rd;
    logic [`REG_NUM_WIDTH-1:0] rs1;
    logic [`REG_NUM_WIDTH-1:0] rs2;
    logic                      isShift;
    logic                      rdNonZero;

    assign opCode    = OpCode'(insn[6:0]);
    assign rd        = insn[11:7];
    assign funct3    = insn[14:12];
    assign rs1       = insn[19:15];
    assign rs2       = insn[24:20];
    assign funct7    = insn[31:25];
    // SLL is 001, SRL/SRA is 101
    assign isShift   = (funct3[1:0] == 2'b01);
    assign rdNonZero = (rd != `ZERO_REGISTER);

    always_comb begin
        mopType      = MOP_ALU;
        srcRegA      = `ZERO_REGISTER;
        srcRegB      = `ZERO_REGISTER;
        dstReg       = `ZERO_REGISTER;
        opTypeA      = OOT_REG;
        opTypeB      = OOT_REG;
        immType      = IMM_NONE;
        writeReg     = 1'b0;
        writePC      = 1'b0;
        isRelBranch  = 1'b0;
        isCall       = 1'b0;
        isReturn     = 1'b0;
        illegalCause = CAUSE_NONE;

        case (opCode)
            RISCV_OP: begin
                if (funct7 == 7'b0000001) begin
                    mopType = funct3[2] ? MOP_DIV : MOP_MUL;
                end else begin
                    mopType = isShift ? MOP_SHIFT : MOP_ALU;
                end
                srcRegA  = rs1;
                srcRegB  = rs2;
                dstReg   = rd;
                writeReg = rdNonZero;
            end
            RISCV_OP_IMM: begin
                mopType  = isShift ? MOP_SHIFT : MOP_ALU;
                srcRegA  = rs1;
                dstReg   = rd;
                opTypeB  = OOT_IMM;
                immType  = IMM_I;
                writeReg = rdNonZero;
            end
            RISCV_LUI, RISCV_AUIPC: begin
                // LUI adds its immediate to x0
                dstReg   = rd;
                opTypeA  = (opCode == RISCV_AUIPC) ? OOT_PC : OOT_REG;
                opTypeB  = OOT_IMM;
                immType  = IMM_U;
                writeReg = rdNonZero;
            end
            RISCV_JAL: begin
                mopType     = MOP_JAL;
                dstReg      = rd;
                opTypeA     = OOT_PC;
                opTypeB     = OOT_IMM;
                immType     = IMM_J;
                writeReg    = rdNonZero;
                writePC     = 1'b1;
                isRelBranch = 1'b1;
                isCall      = rdNonZero && (rd == `LINK_REGISTER);
            end
            RISCV_JALR: begin
                mopType  = MOP_RIJ;
                srcRegA  = rs1;
                dstReg   = rd;
                opTypeB  = OOT_IMM;
                immType  = IMM_I;
                writeReg = rdNonZero;
                writePC  = 1'b1;
                isCall   = rdNonZero && (rd == `LINK_REGISTER);
                isReturn = (rs1 == `LINK_REGISTER) && (rd == `ZERO_REGISTER);
            end
            RISCV_BR: begin
                // Compares two registers, target offset comes from the B immediate
                mopType     = MOP_BR;
                srcRegA     = rs1;
                srcRegB     = rs2;
                immType     = IMM_B;
                writePC     = 1'b1;
                isRelBranch = 1'b1;
            end
            RISCV_LD: begin
                mopType  = MOP_LOAD;
                srcRegA  = rs1;
                dstReg   = rd;
                opTypeB  = OOT_IMM;
                immType  = IMM_I;
                writeReg = rdNonZero;
            end
            RISCV_ST: begin
                // Store data is read through operand B
                mopType = MOP_STORE;
                srcRegA = rs1;
                srcRegB = rs2;
                immType = IMM_S;
            end
            default: begin
                mopType      = MOP_ILLEGAL;
                illegalCause = CAUSE_INSN;
            end
        endcase

        // A fetch fault overrides whatever was decoded
        if (illegalPC) begin
            mopType      = MOP_ILLEGAL;
            writeReg     = 1'b0;
            writePC      = 1'b0;
            isRelBranch  = 1'b0;
            isCall       = 1'b0;
            isReturn     = 1'b0;
            illegalCause = CAUSE_PC_VIOLATION;
        end
    end

endmodule

//--- opFieldDecoder.sv
// --------------------------------------------------
// Funct field decoder
// ALU, branch condition, access mode and mul/div codes
// --------------------------------------------------
`timescale 1ns/10ps
`include "decode_macros.svh"

module opFieldDecoder (
    input  logic [`INSN_WIDTH-1:0] insn,
    input  decodePkg::MopType      mopType,
    output decodePkg::AluCode      aluCode,
    output decodePkg::CondCode     condCode,
    output decodePkg::AccessMode   accessMode,
    output decodePkg::MulDivCode   mulDivCode
);
    import decodePkg::*;

    OpCode      opCode;
    logic [2:0] funct3;
    logic       funct7Alt;
    logic       isRegOp;
    logic       isIntOp;

    assign opCode    = OpCode'(insn[6:0]);
    assign funct3    = insn[14:12];
    assign funct7Alt = insn[30];
    assign isRegOp   = (opCode == RISCV_OP);
    // LUI and AUIPC share MOP_ALU but have no funct3
    assign isIntOp   = isRegOp || (opCode == RISCV_OP_IMM);

    always_comb begin
        aluCode    = ADD;
        condCode   = AL;
        accessMode = WORD;
        mulDivCode = MUL;

        case (mopType)
            MOP_ALU, MOP_SHIFT: begin
                if (isIntOp) begin
                    case (funct3)
                        3'b000:  aluCode = (isRegOp && funct7Alt) ? SUB : ADD;
                        3'b001:  aluCode = SLL;
                        3'b010:  aluCode = SLT;
                        3'b011:  aluCode = SLTU;
                        3'b100:  aluCode = XOR;
                        3'b101:  aluCode = funct7Alt ? SRA : SRL;
                        3'b110:  aluCode = OR;
                        default: aluCode = AND;
                    endcase
                end
            end
            MOP_BR: begin
                case (funct3)
                    3'b000:  condCode = EQ;
                    3'b001:  condCode = NE;
                    3'b100:  condCode = LT;
                    3'b101:  condCode = GE;
                    3'b110:  condCode = LTU;
                    3'b111:  condCode = GEU;
                    default: condCode = AL;
                endcase
            end
            MOP_LOAD, MOP_STORE: begin
                case (funct3)
                    3'b000:  accessMode = BYTE;
                    3'b001:  accessMode = HALF;
                    3'b100:  accessMode = BYTE_U;
                    3'b101:  accessMode = HALF_U;
                    default: accessMode = WORD;
                endcase
            end
            MOP_MUL, MOP_DIV: begin
                mulDivCode = MulDivCode'(funct3);
            end
            default: begin
                aluCode = ADD;
            end
        endcase
    end

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --assert --top-module decodeTb -f src.f -o decodeSim \
    && ./obj_dir/decodeSim \
    || exit 1

//--- src.f
+incdir+.
decodePkg.sv
opClassifier.sv
immGenerator.sv
opFieldDecoder.sv
decodeStageReg.sv
decodeTop.sv
decode_properties.sv
decodeTb.sv
